// ==== src/core_pkg.sv ====
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core definitions: datapath, instruction and register-index widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package core_pkg;

  // Integer datapath width of the RV64 core
  localparam int XLEN = 64;

  // Uncompressed instruction width
  localparam int ILEN = 32;

  localparam int REG_IDX_W = 5;  // Enough to address x0..x31
  localparam int NUM_REGS  = 32;

  // Interrupt number travels with every item for the commit report
  localparam int INTR_W = 32;

endpackage

`default_nettype wire

// ==== src/lsu_pkg.sv ====
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store definitions: memory opcodes and data memory geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package lsu_pkg;

  typedef enum logic [3:0] {
    MEM_NONE = 4'd0,
    MEM_LB   = 4'd1,
    MEM_LH   = 4'd2,
    MEM_LW   = 4'd3,
    MEM_LD   = 4'd4,
    MEM_LBU  = 4'd5,
    MEM_LHU  = 4'd6,
    MEM_LWU  = 4'd7,
    MEM_SB   = 4'd8,
    MEM_SH   = 4'd9,
    MEM_SW   = 4'd10,
    MEM_SD   = 4'd11
  } mem_op_e;

  localparam int DMEM_WORDS  = 256;  // Doublewords in the data memory
  localparam int DMEM_ADDR_W = 11;   // Byte address bits actually decoded

  // Word index and byte offset split of the byte address
  localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);
  localparam int BYTE_OFF_W = DMEM_ADDR_W - DMEM_IDX_W;

endpackage

`default_nettype wire

// ==== src/mem_stage.sv ====
`timescale 1ns/10ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory-access stage: data memory with byte-enabled stores and extended loads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mem_stage (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          i_ex_req,
  output logic                          o_ex_ack,
  input  logic [core_pkg::XLEN-1:0]     i_pc,
  input  logic [core_pkg::ILEN-1:0]     i_inst,
  input  logic [core_pkg::REG_IDX_W-1:0] i_rd,
  input  logic                          i_rd_wen,
  input  logic [core_pkg::XLEN-1:0]     i_alu_res,
  input  logic [core_pkg::XLEN-1:0]     i_store_data,
  input  lsu_pkg::mem_op_e              i_mem_op,
  input  logic                          i_nocmt,
  input  logic                          i_skipcmt,
  input  logic [core_pkg::INTR_W-1:0]   i_intr_no,
  input  logic                          i_clint_mip,
  output logic                          o_mem_req,
  input  logic                          i_mem_ack,
  output logic [core_pkg::XLEN-1:0]     o_pc,
  output logic [core_pkg::ILEN-1:0]     o_inst,
  output logic [core_pkg::REG_IDX_W-1:0] o_rd,
  output logic                          o_rd_wen,
  output logic [core_pkg::XLEN-1:0]     o_rd_wdata,
  output logic                          o_nocmt,
  output logic                          o_skipcmt,
  output logic [core_pkg::INTR_W-1:0]   o_intr_no,
  output logic                          o_clint_mip
);
  import core_pkg::*;
  import lsu_pkg::*;

  logic                  ex_hs;
  logic [DMEM_IDX_W-1:0] word_idx;
  logic [BYTE_OFF_W-1:0] byte_off;
  logic [XLEN/8-1:0]     byte_en;
  logic [XLEN-1:0]       st_data_sh;
  logic [XLEN-1:0]       ld_word;
  logic [XLEN-1:0]       ld_data;

  logic [XLEN-1:0]       dmem [DMEM_WORDS];

  logic [XLEN-1:0]       pc_q;
  logic [ILEN-1:0]       inst_q;
  logic [REG_IDX_W-1:0]  rd_q;
  logic                  rd_wen_q;
  logic [XLEN-1:0]       wdata_q;
  logic                  nocmt_q;
  logic                  skipcmt_q;
  logic [INTR_W-1:0]     intr_no_q;
  logic                  mip_q;

  assign o_ex_ack = 1'b1;  // No back-pressure toward execute
  assign ex_hs    = i_ex_req & o_ex_ack;

  assign word_idx   = i_alu_res[DMEM_ADDR_W-1:BYTE_OFF_W];
  assign byte_off   = i_alu_res[BYTE_OFF_W-1:0];
  assign st_data_sh = i_store_data << {byte_off, 3'b000};

  always_comb begin
    case (i_mem_op)
      MEM_SB:  byte_en = 8'h01 << byte_off;
      MEM_SH:  byte_en = 8'h03 << byte_off;
      MEM_SW:  byte_en = 8'h0f << byte_off;
      MEM_SD:  byte_en = 8'hff;
      default: byte_en = '0;
    endcase
  end

  // Store merges only the enabled bytes into the addressed doubleword
  always_ff @(posedge clk) begin
    if (ex_hs) begin
      for (int b = 0; b < XLEN / 8; b++) begin
        if (byte_en[b]) begin
          dmem[word_idx][b*8 +: 8] <= st_data_sh[b*8 +: 8];
        end
      end
    end
  end

  always_comb begin
    ld_word = dmem[word_idx] >> {byte_off, 3'b000};  // Field lands in the low bits
    case (i_mem_op)
      MEM_LB:  ld_data = {{(XLEN-8){ld_word[7]}}, ld_word[7:0]};
      MEM_LH:  ld_data = {{(XLEN-16){ld_word[15]}}, ld_word[15:0]};
      MEM_LW:  ld_data = {{(XLEN-32){ld_word[31]}}, ld_word[31:0]};
      MEM_LD:  ld_data = ld_word;
      MEM_LBU: ld_data = {{(XLEN-8){1'b0}}, ld_word[7:0]};
      MEM_LHU: ld_data = {{(XLEN-16){1'b0}}, ld_word[15:0]};
      MEM_LWU: ld_data = {{(XLEN-32){1'b0}}, ld_word[31:0]};
      default: ld_data = i_alu_res;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_mem_req <= 1'b0;
    end else if (ex_hs) begin
      o_mem_req <= 1'b1;  // A fresh item wins over a pending ack
    end else if (i_mem_ack) begin
      o_mem_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_hs) begin
      pc_q      <= i_pc;
      inst_q    <= i_inst;
      rd_q      <= i_rd;
      rd_wen_q  <= i_rd_wen;
      wdata_q   <= ld_data;
      nocmt_q   <= i_nocmt;
      skipcmt_q <= i_skipcmt;
      intr_no_q <= i_intr_no;
      mip_q     <= i_clint_mip;
    end
  end

  assign o_pc        = o_mem_req ? pc_q      : '0;
  assign o_inst      = o_mem_req ? inst_q    : '0;
  assign o_rd        = o_mem_req ? rd_q      : '0;
  assign o_rd_wen    = o_mem_req ? rd_wen_q  : 1'b0;
  assign o_rd_wdata  = o_mem_req ? wdata_q   : '0;
  assign o_nocmt     = o_mem_req ? nocmt_q   : 1'b0;
  assign o_skipcmt   = o_mem_req ? skipcmt_q : 1'b0;
  assign o_intr_no   = o_mem_req ? intr_no_q : '0;
  assign o_clint_mip = o_mem_req ? mip_q     : 1'b0;

endmodule

`default_nettype wire

// ==== src/wb_stage.sv ====
`timescale 1ns/10ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Writeback stage: holds one item, writes the register file, requests commit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module wb_stage (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           i_mem_req,
  output logic                           o_mem_ack,
  input  logic [core_pkg::XLEN-1:0]      i_pc,
  input  logic [core_pkg::ILEN-1:0]      i_inst,
  input  logic [core_pkg::REG_IDX_W-1:0] i_rd,
  input  logic                           i_rd_wen,
  input  logic [core_pkg::XLEN-1:0]      i_rd_wdata,
  input  logic                           i_nocmt,
  input  logic                           i_skipcmt,
  input  logic [core_pkg::INTR_W-1:0]    i_intr_no,
  input  logic                           i_clint_mip,
  output logic                           o_wb_req,
  input  logic                           i_wb_ack,
  output logic [core_pkg::XLEN-1:0]      o_pc,
  output logic [core_pkg::ILEN-1:0]      o_inst,
  output logic                           o_nocmt,
  output logic                           o_skipcmt,
  output logic [core_pkg::INTR_W-1:0]    o_intr_no,
  output logic                           o_clint_mip,
  output logic                           o_reg_we,
  output logic [core_pkg::REG_IDX_W-1:0] o_reg_waddr,
  output logic [core_pkg::XLEN-1:0]      o_reg_wdata
);
  import core_pkg::*;

  logic                 mem_hs;
  logic [XLEN-1:0]      pc_q;
  logic [ILEN-1:0]      inst_q;
  logic [REG_IDX_W-1:0] rd_q;
  logic                 rd_wen_q;
  logic [XLEN-1:0]      wdata_q;
  logic                 nocmt_q;
  logic                 skipcmt_q;
  logic [INTR_W-1:0]    intr_no_q;
  logic                 mip_q;

  assign o_mem_ack = 1'b1;
  assign mem_hs    = i_mem_req & o_mem_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_wb_req <= 1'b0;
    end else if (mem_hs) begin
      o_wb_req <= 1'b1;
    end else if (i_wb_ack) begin
      o_wb_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_hs) begin
      pc_q      <= i_pc;
      inst_q    <= i_inst;
      rd_q      <= i_rd;
      rd_wen_q  <= i_rd_wen;
      wdata_q   <= i_rd_wdata;
      nocmt_q   <= i_nocmt;
      skipcmt_q <= i_skipcmt;
      intr_no_q <= i_intr_no;
      mip_q     <= i_clint_mip;
    end
  end

  // The register write lands on the same edge as the commit handshake
  assign o_reg_we    = o_wb_req & i_wb_ack & rd_wen_q;
  assign o_reg_waddr = o_wb_req ? rd_q    : '0;
  assign o_reg_wdata = o_wb_req ? wdata_q : '0;

  assign o_pc        = o_wb_req ? pc_q      : '0;
  assign o_inst      = o_wb_req ? inst_q    : '0;
  assign o_nocmt     = o_wb_req ? nocmt_q   : 1'b0;
  assign o_skipcmt   = o_wb_req ? skipcmt_q : 1'b0;
  assign o_intr_no   = o_wb_req ? intr_no_q : '0;
  assign o_clint_mip = o_wb_req ? mip_q     : 1'b0;

endmodule

`default_nettype wire

// ==== src/regfile.sv ====
`timescale 1ns/10ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer register file, one write port and one combinational read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module regfile (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           i_we,
  input  logic [core_pkg::REG_IDX_W-1:0] i_waddr,
  input  logic [core_pkg::XLEN-1:0]      i_wdata,
  input  logic [core_pkg::REG_IDX_W-1:0] i_raddr,
  output logic [core_pkg::XLEN-1:0]      o_rdata
);
  import core_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else if (i_we && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;  // x0 is hardwired and never written
    end
  end

  assign o_rdata = (i_raddr == '0) ? '0 : regs[i_raddr];

endmodule

`default_nettype wire

// ==== src/commit_unit.sv ====
`timescale 1ns/10ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Commit unit: one-cycle retirement report and retired-instruction counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module commit_unit (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_wb_req,
  output logic                        o_wb_ack,
  input  logic [core_pkg::XLEN-1:0]   i_pc,
  input  logic [core_pkg::ILEN-1:0]   i_inst,
  input  logic                        i_nocmt,
  input  logic                        i_skipcmt,
  input  logic [core_pkg::INTR_W-1:0] i_intr_no,
  input  logic                        i_clint_mip,
  output logic                        o_commit_valid,
  output logic [core_pkg::XLEN-1:0]   o_commit_pc,
  output logic [core_pkg::ILEN-1:0]   o_commit_inst,
  output logic                        o_commit_skip,
  output logic [core_pkg::INTR_W-1:0] o_commit_intr_no,
  output logic                        o_commit_mip,
  output logic [core_pkg::XLEN-1:0]   o_instret
);

  logic wb_hs;

  assign o_wb_ack = 1'b1;
  assign wb_hs    = i_wb_req & o_wb_ack;

  // Report fields drop back to zero in cycles without a retirement
  always_ff @(posedge clk) begin
    if (rst || !wb_hs) begin
      o_commit_valid   <= 1'b0;
      o_commit_pc      <= '0;
      o_commit_inst    <= '0;
      o_commit_skip    <= 1'b0;
      o_commit_intr_no <= '0;
      o_commit_mip     <= 1'b0;
    end else begin
      o_commit_valid   <= ~i_nocmt;  // Suppressed items retire silently
      o_commit_pc      <= i_pc;
      o_commit_inst    <= i_inst;
      o_commit_skip    <= i_skipcmt;
      o_commit_intr_no <= i_intr_no;
      o_commit_mip     <= i_clint_mip;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_instret <= '0;
    end else if (wb_hs && !i_nocmt) begin
      o_instret <= o_instret + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/mem_wb_top.sv ====
`timescale 1ns/10ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipeline tail: memory, writeback, register file and commit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mem_wb_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           i_ex_req,
  output logic                           o_ex_ack,
  input  logic [core_pkg::XLEN-1:0]      i_pc,
  input  logic [core_pkg::ILEN-1:0]      i_inst,
  input  logic [core_pkg::REG_IDX_W-1:0] i_rd,
  input  logic                           i_rd_wen,
  input  logic [core_pkg::XLEN-1:0]      i_alu_res,
  input  logic [core_pkg::XLEN-1:0]      i_store_data,
  input  lsu_pkg::mem_op_e               i_mem_op,
  input  logic                           i_nocmt,
  input  logic                           i_skipcmt,
  input  logic [core_pkg::INTR_W-1:0]    i_intr_no,
  input  logic                           i_clint_mip,
  input  logic [core_pkg::REG_IDX_W-1:0] i_dbg_raddr,
  output logic                           o_commit_valid,
  output logic [core_pkg::XLEN-1:0]      o_commit_pc,
  output logic [core_pkg::ILEN-1:0]      o_commit_inst,
  output logic                           o_commit_skip,
  output logic [core_pkg::INTR_W-1:0]    o_commit_intr_no,
  output logic                           o_commit_mip,
  output logic [core_pkg::XLEN-1:0]      o_instret,
  output logic [core_pkg::XLEN-1:0]      o_dbg_rdata
);
  import core_pkg::*;

  // Memory to writeback link
  logic                 mem_req;
  logic                 mem_ack;
  logic [XLEN-1:0]      mem_pc;
  logic [ILEN-1:0]      mem_inst;
  logic [REG_IDX_W-1:0] mem_rd;
  logic                 mem_rd_wen;
  logic [XLEN-1:0]      mem_rd_wdata;
  logic                 mem_nocmt;
  logic                 mem_skipcmt;
  logic [INTR_W-1:0]    mem_intr_no;
  logic                 mem_mip;

  // Writeback to commit link
  logic                 wb_req;
  logic                 wb_ack;
  logic [XLEN-1:0]      wb_pc;
  logic [ILEN-1:0]      wb_inst;
  logic                 wb_nocmt;
  logic                 wb_skipcmt;
  logic [INTR_W-1:0]    wb_intr_no;
  logic                 wb_mip;

  logic                 reg_we;
  logic [REG_IDX_W-1:0] reg_waddr;
  logic [XLEN-1:0]      reg_wdata;

  mem_stage u_mem_stage (
    .clk (clk), .rst (rst),
    .i_ex_req (i_ex_req), .o_ex_ack (o_ex_ack),
    .i_pc (i_pc), .i_inst (i_inst), .i_rd (i_rd), .i_rd_wen (i_rd_wen),
    .i_alu_res (i_alu_res), .i_store_data (i_store_data), .i_mem_op (i_mem_op),
    .i_nocmt (i_nocmt), .i_skipcmt (i_skipcmt),
    .i_intr_no (i_intr_no), .i_clint_mip (i_clint_mip),
    .o_mem_req (mem_req), .i_mem_ack (mem_ack),
    .o_pc (mem_pc), .o_inst (mem_inst), .o_rd (mem_rd), .o_rd_wen (mem_rd_wen),
    .o_rd_wdata (mem_rd_wdata), .o_nocmt (mem_nocmt), .o_skipcmt (mem_skipcmt),
    .o_intr_no (mem_intr_no), .o_clint_mip (mem_mip)
  );

  wb_stage u_wb_stage (
    .clk (clk), .rst (rst),
    .i_mem_req (mem_req), .o_mem_ack (mem_ack),
    .i_pc (mem_pc), .i_inst (mem_inst), .i_rd (mem_rd), .i_rd_wen (mem_rd_wen),
    .i_rd_wdata (mem_rd_wdata), .i_nocmt (mem_nocmt), .i_skipcmt (mem_skipcmt),
    .i_intr_no (mem_intr_no), .i_clint_mip (mem_mip),
    .o_wb_req (wb_req), .i_wb_ack (wb_ack),
    .o_pc (wb_pc), .o_inst (wb_inst), .o_nocmt (wb_nocmt), .o_skipcmt (wb_skipcmt),
    .o_intr_no (wb_intr_no), .o_clint_mip (wb_mip),
    .o_reg_we (reg_we), .o_reg_waddr (reg_waddr), .o_reg_wdata (reg_wdata)
  );

  regfile u_regfile (
    .clk (clk), .rst (rst),
    .i_we (reg_we), .i_waddr (reg_waddr), .i_wdata (reg_wdata),
    .i_raddr (i_dbg_raddr), .o_rdata (o_dbg_rdata)
  );

  commit_unit u_commit_unit (
    .clk (clk), .rst (rst),
    .i_wb_req (wb_req), .o_wb_ack (wb_ack),
    .i_pc (wb_pc), .i_inst (wb_inst), .i_nocmt (wb_nocmt), .i_skipcmt (wb_skipcmt),
    .i_intr_no (wb_intr_no), .i_clint_mip (wb_mip),
    .o_commit_valid (o_commit_valid), .o_commit_pc (o_commit_pc),
    .o_commit_inst (o_commit_inst), .o_commit_skip (o_commit_skip),
    .o_commit_intr_no (o_commit_intr_no), .o_commit_mip (o_commit_mip),
    .o_instret (o_instret)
  );

endmodule

`default_nettype wire

// ==== tests/tb_mem_wb.sv ====
`timescale 1ns/10ps
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the pipeline tail: random items checked against a model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_mem_wb;
  import core_pkg::*;
  import lsu_pkg::*;

  localparam int CLK_PERIOD      = 20;
  localparam int NUM_TESTS       = 2000;
  localparam int FILL_ITEMS      = DMEM_WORDS;  // One doubleword store per memory word
  localparam int WATCHDOG_CYCLES = (FILL_ITEMS + NUM_TESTS) * 20 + 500;

  typedef struct packed {
    logic [63:0]       due;
    logic [XLEN-1:0]   pc;
    logic [ILEN-1:0]   inst;
    logic              skip;
    logic [INTR_W-1:0] intr_no;
    logic              mip;
  } exp_commit_t;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 i_ex_req;
  logic                 o_ex_ack;
  logic [XLEN-1:0]      i_pc;
  logic [ILEN-1:0]      i_inst;
  logic [REG_IDX_W-1:0] i_rd;
  logic                 i_rd_wen;
  logic [XLEN-1:0]      i_alu_res;
  logic [XLEN-1:0]      i_store_data;
  mem_op_e              i_mem_op;
  logic                 i_nocmt;
  logic                 i_skipcmt;
  logic [INTR_W-1:0]    i_intr_no;
  logic                 i_clint_mip;
  logic [REG_IDX_W-1:0] i_dbg_raddr;
  logic                 o_commit_valid;
  logic [XLEN-1:0]      o_commit_pc;
  logic [ILEN-1:0]      o_commit_inst;
  logic                 o_commit_skip;
  logic [INTR_W-1:0]    o_commit_intr_no;
  logic                 o_commit_mip;
  logic [XLEN-1:0]      o_instret;
  logic [XLEN-1:0]      o_dbg_rdata;

  logic [XLEN-1:0] model_regs [NUM_REGS];
  logic [7:0]      model_mem [1 << DMEM_ADDR_W];
  exp_commit_t     exp_q [$];
  logic [63:0]     edge_cnt = '0;
  logic [XLEN-1:0] exp_instret = '0;   // Count visible on o_instret right now
  logic [XLEN-1:0] commit_count = '0;  // Every item sent that must retire
  int              seed = 32'h7bc3_4dc0;

  mem_wb_top UUT (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) edge_cnt <= edge_cnt + 64'd1;

  function automatic int access_bytes(input mem_op_e op);
    case (op)
      MEM_LB, MEM_LBU, MEM_SB: return 1;
      MEM_LH, MEM_LHU, MEM_SH: return 2;
      MEM_LW, MEM_LWU, MEM_SW: return 4;
      default:                 return 8;
    endcase
  endfunction

  // Little-endian gather from the byte model, then sign fill for signed loads
  function automatic logic [XLEN-1:0] model_load(input mem_op_e op,
                                                 input logic [DMEM_ADDR_W-1:0] addr);
    logic [XLEN-1:0] raw;
    int              n;
    n   = access_bytes(op);
    raw = '0;
    for (int i = 0; i < n; i++) begin
      raw[8*i +: 8] = model_mem[int'(addr) + i];
    end
    if ((op inside {MEM_LB, MEM_LH, MEM_LW}) && raw[8*n-1]) begin
      for (int i = 8 * n; i < XLEN; i++) begin
        raw[i] = 1'b1;
      end
    end
    return raw;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first mismatch");
  endtask

  task automatic check_commit(input logic valid, input logic [XLEN-1:0] pc,
                              input logic [ILEN-1:0] inst, input logic skip,
                              input logic [INTR_W-1:0] intr_no, input logic mip);
    if (o_commit_valid !== valid || (valid && (o_commit_pc !== pc ||
        o_commit_inst !== inst || o_commit_skip !== skip ||
        o_commit_intr_no !== intr_no || o_commit_mip !== mip))) begin
      stop_on_error($sformatf("commit v=%0b pc=%h inst=%h skip=%0b intr=%h mip=%0b, %s",
                              o_commit_valid, o_commit_pc, o_commit_inst, o_commit_skip,
                              o_commit_intr_no, o_commit_mip,
                              $sformatf("expected v=%0b pc=%h inst=%h skip=%0b intr=%h mip=%0b",
                                        valid, pc, inst, skip, intr_no, mip)));
    end
  endtask

  task automatic check_reg(input logic [REG_IDX_W-1:0] idx, input logic [XLEN-1:0] exp,
                           input logic [XLEN-1:0] got);
    if (got !== exp) begin
      stop_on_error($sformatf("x%0d reads %h, expected %h", idx, got, exp));
    end
  endtask

  task automatic check_instret(input logic [XLEN-1:0] exp, input logic [XLEN-1:0] got);
    if (got !== exp) begin
      stop_on_error($sformatf("instret is %0d, expected %0d", got, exp));
    end
  endtask

  // Execute never sees back-pressure, so its ack must stay high
  task automatic check_ack(input logic got);
    if (got !== 1'b1) begin
      stop_on_error($sformatf("execute ack is %b, expected 1", got));
    end
  endtask

  task automatic check_commit_slot();
    exp_commit_t e;
    if (exp_q.size() > 0 && exp_q[0].due == edge_cnt) begin
      e = exp_q.pop_front();
      exp_instret = exp_instret + 64'd1;
      check_commit(1'b1, e.pc, e.inst, e.skip, e.intr_no, e.mip);
    end else begin
      check_commit(1'b0, '0, '0, 1'b0, '0, 1'b0);
    end
    check_instret(exp_instret, o_instret);
  endtask

  // Outputs settle at the edge, new inputs go out 1 ns later
  task automatic next_cycle();
    @(posedge clk);
    #1;
    check_commit_slot();
    check_ack(o_ex_ack);
  endtask

  task automatic record_item();
    exp_commit_t            e;
    logic [DMEM_ADDR_W-1:0] addr;
    addr = i_alu_res[DMEM_ADDR_W-1:0];
    if (i_mem_op inside {MEM_SB, MEM_SH, MEM_SW, MEM_SD}) begin
      for (int i = 0; i < access_bytes(i_mem_op); i++) begin
        model_mem[int'(addr) + i] = i_store_data[8*i +: 8];
      end
    end
    if (i_rd_wen && i_rd != '0) begin
      if (i_mem_op inside {[MEM_LB:MEM_LWU]}) begin
        model_regs[i_rd] = model_load(i_mem_op, addr);
      end else begin
        model_regs[i_rd] = i_alu_res;
      end
    end
    if (!i_nocmt) begin
      e = '{edge_cnt + 64'd3, i_pc, i_inst, i_skipcmt, i_intr_no, i_clint_mip};
      exp_q.push_back(e);
      commit_count = commit_count + 64'd1;
    end
  endtask

  // A fill item is a doubleword store that initializes one memory word
  task automatic drive_item(input logic fill, input int word);
    logic [31:0]            op_sel;
    mem_op_e                op;
    logic [DMEM_ADDR_W-1:0] addr;
    op_sel = $unsigned($random(seed)) % 12;
    op     = fill ? MEM_SD : mem_op_e'(op_sel[3:0]);
    addr   = fill ? DMEM_ADDR_W'(word * 8) : DMEM_ADDR_W'($random(seed));
    addr   = addr & ~DMEM_ADDR_W'(access_bytes(op) - 1);  // Natural alignment
    i_ex_req     = 1'b1;
    i_pc         = {$random(seed), $random(seed)};
    i_inst       = $random(seed);
    i_rd         = REG_IDX_W'($random(seed));
    i_rd_wen     = !fill && (($random(seed) & 3) != 0);
    i_alu_res    = {$random(seed), $random(seed)};
    if (op != MEM_NONE) begin
      i_alu_res[DMEM_ADDR_W-1:0] = addr;
    end
    i_store_data = {$random(seed), $random(seed)};
    i_mem_op     = op;
    i_nocmt      = !fill && (($random(seed) & 7) == 0);
    i_skipcmt    = ($random(seed) & 1) != 0;
    i_intr_no    = $random(seed);
    i_clint_mip  = ($random(seed) & 1) != 0;
    record_item();
  endtask

  task automatic read_back_regs();
    for (int r = 0; r < NUM_REGS; r++) begin
      next_cycle();
      i_dbg_raddr = REG_IDX_W'(r);
      #2;
      check_reg(REG_IDX_W'(r), model_regs[r], o_dbg_rdata);
    end
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    rst          = 1'b1;
    i_ex_req     = 1'b0;
    i_pc         = '0;
    i_inst       = '0;
    i_rd         = '0;
    i_rd_wen     = 1'b0;
    i_alu_res    = '0;
    i_store_data = '0;
    i_mem_op     = MEM_NONE;
    i_nocmt      = 1'b0;
    i_skipcmt    = 1'b0;
    i_intr_no    = '0;
    i_clint_mip  = 1'b0;
    i_dbg_raddr  = '0;
    for (int r = 0; r < NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    read_back_regs();  // Reset state of the report, counter and registers
    for (int w = 0; w < FILL_ITEMS; w++) begin
      next_cycle();
      drive_item(1'b1, w);
    end
    for (int t = 0; t < NUM_TESTS; t++) begin
      next_cycle();
      if (($random(seed) & 3) == 0) begin
        i_ex_req = 1'b0;  // Bubble between bursts of back-to-back items
      end else begin
        drive_item(1'b0, 0);
      end
    end
    next_cycle();
    i_ex_req = 1'b0;
    while (exp_q.size() > 0) begin
      next_cycle();
    end
    repeat (5) next_cycle();
    check_instret(commit_count, o_instret);
    read_back_regs();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
src/core_pkg.sv
src/lsu_pkg.sv
src/mem_stage.sv
src/wb_stage.sv
src/regfile.sv
src/commit_unit.sv
src/mem_wb_top.sv
tests/tb_mem_wb.sv

// ==== Makefile ====
TOP := tb_mem_wb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /^TEST OK$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
